/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = csr_unit_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* files.f */
+incdir+tb
hw/csr_pkg.sv
hw/csr_decode.sv
hw/csr_file.sv
hw/csr_exec.sv
hw/csr_unit.sv
tb/csr_unit_tb.sv

/* hw/csr_decode.sv */
// Combinational decoder for SYSTEM instructions.
// Maps an instruction word to a CSR operation, slot, rd and operand.
// Anything that is not a supported SYSTEM encoding comes out as op_illegal.

`timescale 1ns/1ps

module csr_decode (
    input  csr_pkg::csr_req_t req,
    output csr_pkg::csr_dec_t dec
);
    import csr_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [4:0]  rs1_field;
    logic [4:0]  rd_field;
    logic [11:0] csr_addr;
    logic        addr_known;
    csr_idx_t    addr_idx;

    assign opcode    = req.instr[6:0];
    assign rd_field  = req.instr[11:7];
    assign funct3    = req.instr[14:12];
    assign rs1_field = req.instr[19:15];
    assign csr_addr  = req.instr[31:20];

    // csr address to register slot
    always_comb begin
        addr_known = 1'b1;
        addr_idx   = idx_mstatus;
        case (csr_addr)
            csr_addr_mstatus: addr_idx = idx_mstatus;
            csr_addr_mtvec:   addr_idx = idx_mtvec;
            csr_addr_mepc:    addr_idx = idx_mepc;
            csr_addr_mcause:  addr_idx = idx_mcause;
            default:          addr_known = 1'b0;
        endcase
    end

    always_comb begin
        dec.op       = op_none;
        dec.idx      = addr_idx;
        dec.rd       = rd_field[3:0];
        dec.src_zero = (rs1_field == 5'd0);
        // funct3[2] selects the uimm forms
        dec.operand  = funct3[2] ? {27'd0, rs1_field} : req.rs1_data;

        if (req.valid) begin
            if (opcode != opcode_system) begin
                dec.op = op_illegal;
            end else if (funct3 == 3'b000) begin
                // ecall and mret need zero rs1 and rd fields
                if (rs1_field != 5'd0 || rd_field != 5'd0) begin
                    dec.op = op_illegal;
                end else if (csr_addr == funct12_ecall) begin
                    dec.op      = op_ecall;
                    // operand is free here, it carries the trapping pc
                    dec.operand = req.pc;
                end else if (csr_addr == funct12_mret) begin
                    dec.op = op_mret;
                end else begin
                    dec.op = op_illegal;
                end
            end else if (funct3 == 3'b100) begin
                dec.op = op_illegal;
            end else if (!addr_known) begin
                dec.op = op_illegal;
            end else if (rd_field[4] || (!funct3[2] && rs1_field[4])) begin
                // RV32E has only x0..x15
                dec.op = op_illegal;
            end else begin
                case (funct3[1:0])
                    2'b01:   dec.op = op_rw;
                    2'b10:   dec.op = op_rs;
                    2'b11:   dec.op = op_rc;
                    default: dec.op = op_illegal;
                endcase
            end
        end
    end

endmodule

/* hw/csr_exec.sv */
// Execute stage of the CSR unit.
// Reads the old CSR value, forms the read-modify-write result, drives the
// write port and trap strobes, and registers the response for one cycle.

`timescale 1ns/1ps

module csr_exec (
    input  logic              clk,
    input  logic              rst,
    input  csr_pkg::csr_dec_t dec,
    output csr_pkg::csr_idx_t rd_idx,
    input  logic [31:0]       rd_data,
    input  logic [31:0]       mtvec,
    input  logic [31:0]       mepc,
    output csr_pkg::csr_wr_t  wr,
    output logic              trap_enter,
    output logic              trap_return,
    output logic [31:0]       epc,
    output csr_pkg::csr_resp_t resp
);
    import csr_pkg::*;

    logic        is_zicsr;
    logic        do_write;
    logic [31:0] new_value;
    csr_resp_t   resp_d;
    csr_resp_t   resp_q;

    assign rd_idx = dec.idx;

    always_comb begin
        is_zicsr  = 1'b0;
        do_write  = 1'b0;
        new_value = rd_data;
        case (dec.op)
            op_rw: begin
                is_zicsr  = 1'b1;
                do_write  = 1'b1;
                new_value = dec.operand;
            end
            op_rs: begin
                is_zicsr  = 1'b1;
                do_write  = !dec.src_zero;
                new_value = rd_data | dec.operand;
            end
            op_rc: begin
                is_zicsr  = 1'b1;
                do_write  = !dec.src_zero;
                new_value = rd_data & ~dec.operand;
            end
            default: begin
                is_zicsr = 1'b0;
            end
        endcase
    end

    assign wr.we       = do_write;
    assign wr.idx      = dec.idx;
    assign wr.data     = new_value;

    assign trap_enter  = (dec.op == op_ecall);
    assign trap_return = (dec.op == op_mret);
    // decode routes the pc through operand on ecall
    assign epc         = dec.operand;

    always_comb begin
        resp_d.valid       = (dec.op != op_none);
        resp_d.rd_we       = is_zicsr && (dec.rd != 4'd0);
        resp_d.rd          = dec.rd;
        resp_d.rd_data     = is_zicsr ? rd_data : 32'd0;
        resp_d.redirect    = trap_enter || trap_return;
        resp_d.illegal     = (dec.op == op_illegal);
        // mtvec and mepc are still the old values in this cycle
        if (trap_enter) begin
            resp_d.redirect_pc = mtvec;
        end else if (trap_return) begin
            resp_d.redirect_pc = mepc;
        end else begin
            resp_d.redirect_pc = 32'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_q.valid    <= 1'b0;
            resp_q.rd_we    <= 1'b0;
            resp_q.redirect <= 1'b0;
            resp_q.illegal  <= 1'b0;
        end else begin
            resp_q <= resp_d;
        end
    end

    assign resp = resp_q;

endmodule

/* hw/csr_file.sv */
// The four machine CSRs: mstatus, mtvec, mepc and mcause.
// One combinational read port, one write port, plus trap entry and
// trap return strobes that update the trap fields at the next edge.

`timescale 1ns/1ps

module csr_file #(
    parameter logic [31:0] MTVEC_RESET = 32'h0
) (
    input  logic              clk,
    input  logic              rst,
    input  csr_pkg::csr_idx_t rd_idx,
    output logic [31:0]       rd_data,
    input  csr_pkg::csr_wr_t  wr,
    input  logic              trap_enter,
    input  logic              trap_return,
    input  logic [31:0]       epc,
    output logic [31:0]       mtvec,
    output logic [31:0]       mepc
);
    import csr_pkg::*;

    logic [31:0] csr_q    [4];
    logic [31:0] csr_next [4];
    logic        wr_sel   [4];
    logic        rd_sel   [4];
    logic [31:0] rd_chain [4];

    genvar j;
    generate
        for (j = 0; j < 4; j = j + 1) begin : g_sel
            assign wr_sel[j] = wr.we && (wr.idx == csr_idx_t'(j));
            assign rd_sel[j] = (rd_idx == csr_idx_t'(j));
        end
    endgenerate

    // one-hot read mux as an or chain
    assign rd_chain[0] = {32{rd_sel[0]}} & csr_q[0];
    generate
        for (j = 1; j < 4; j = j + 1) begin : g_rd
            assign rd_chain[j] = rd_chain[j-1] | ({32{rd_sel[j]}} & csr_q[j]);
        end
    endgenerate

    assign rd_data = rd_chain[3];
    assign mtvec   = csr_q[idx_mtvec];
    assign mepc    = csr_q[idx_mepc];

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            csr_next[i] = wr_sel[i] ? wr.data : csr_q[i];
        end
        if (trap_enter) begin
            csr_next[idx_mepc]   = epc;
            csr_next[idx_mcause] = mcause_ecall_m;
            csr_next[idx_mstatus][mstatus_mpie] = csr_q[idx_mstatus][mstatus_mie];
            csr_next[idx_mstatus][mstatus_mie]  = 1'b0;
        end else if (trap_return) begin
            csr_next[idx_mstatus][mstatus_mie]  = csr_q[idx_mstatus][mstatus_mpie];
            csr_next[idx_mstatus][mstatus_mpie] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            csr_q[idx_mstatus] <= mstatus_reset;
            csr_q[idx_mtvec]   <= MTVEC_RESET;
            csr_q[idx_mepc]    <= 32'd0;
            csr_q[idx_mcause]  <= 32'd0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                csr_q[i] <= csr_next[i];
            end
        end
    end

endmodule

/* hw/csr_pkg.sv */
// Shared types and constants for the machine-mode CSR unit.
// Imported by decode, execute, the CSR file and the top level.

package csr_pkg;

    // slot of each implemented CSR in the register file
    typedef enum logic [1:0] {
        idx_mstatus = 2'd0,
        idx_mtvec   = 2'd1,
        idx_mepc    = 2'd2,
        idx_mcause  = 2'd3
    } csr_idx_t;

    typedef enum logic [2:0] {
        op_none,
        op_rw,
        op_rs,
        op_rc,
        op_ecall,
        op_mret,
        op_illegal
    } csr_op_t;

    // request from the decode stage of the core
    typedef struct packed {
        logic        valid;
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] rs1_data;
    } csr_req_t;

    typedef struct packed {
        csr_op_t     op;
        csr_idx_t    idx;
        logic [3:0]  rd;
        logic [31:0] operand;
        logic        src_zero;
    } csr_dec_t;

    typedef struct packed {
        logic        we;
        csr_idx_t    idx;
        logic [31:0] data;
    } csr_wr_t;

    typedef struct packed {
        logic        valid;
        logic        rd_we;
        logic [3:0]  rd;
        logic [31:0] rd_data;
        logic        redirect;
        logic [31:0] redirect_pc;
        logic        illegal;
    } csr_resp_t;

    localparam logic [6:0]  opcode_system    = 7'b1110011;
    localparam logic [11:0] funct12_ecall    = 12'h000;
    localparam logic [11:0] funct12_mret     = 12'h302;

    localparam logic [11:0] csr_addr_mstatus = 12'h300;
    localparam logic [11:0] csr_addr_mtvec   = 12'h305;
    localparam logic [11:0] csr_addr_mepc    = 12'h341;
    localparam logic [11:0] csr_addr_mcause  = 12'h342;

    localparam int          mstatus_mie      = 3;
    localparam int          mstatus_mpie     = 7;
    localparam logic [31:0] mstatus_reset    = 32'h0000_1800;
    localparam logic [31:0] mcause_ecall_m   = 32'd11;

endpackage

/* hw/csr_unit.sv */
// Top level of the machine-mode CSR unit for an RV32E core.
// Accepts one request per cycle and returns a registered response
// one cycle later. MTVEC_RESET sets the trap vector after reset.

`timescale 1ns/1ps

module csr_unit #(
    parameter logic [31:0] MTVEC_RESET = 32'h0
) (
    input  logic               clk,
    input  logic               rst,
    input  csr_pkg::csr_req_t  req,
    output csr_pkg::csr_resp_t resp
);
    import csr_pkg::*;

    csr_dec_t    dec;
    csr_idx_t    rd_idx;
    logic [31:0] rd_data;
    csr_wr_t     wr;
    logic        trap_enter;
    logic        trap_return;
    logic [31:0] epc;
    logic [31:0] mtvec;
    logic [31:0] mepc;

    csr_decode csr_decode_i (
        .req (req),
        .dec (dec)
    );

    csr_exec csr_exec_i (
        .clk         (clk),
        .rst         (rst),
        .dec         (dec),
        .rd_idx      (rd_idx),
        .rd_data     (rd_data),
        .mtvec       (mtvec),
        .mepc        (mepc),
        .wr          (wr),
        .trap_enter  (trap_enter),
        .trap_return (trap_return),
        .epc         (epc),
        .resp        (resp)
    );

    csr_file #(
        .MTVEC_RESET (MTVEC_RESET)
    ) csr_file_i (
        .clk         (clk),
        .rst         (rst),
        .rd_idx      (rd_idx),
        .rd_data     (rd_data),
        .wr          (wr),
        .trap_enter  (trap_enter),
        .trap_return (trap_return),
        .epc         (epc),
        .mtvec       (mtvec),
        .mepc        (mepc)
    );

endmodule

/* tb/csr_vectors.svh */
// Request table for the CSR unit testbench, one row per clock.
// Each row holds a request and the response expected one cycle later.
// Included inside csr_unit_tb after the csr_pkg import.

`ifndef csr_vectors_svh
`define csr_vectors_svh

typedef struct packed {
    csr_req_t    req;
    logic        exp_valid;
    logic        exp_rd_we;
    logic [3:0]  exp_rd;
    logic [31:0] exp_rd_data;
    logic        exp_redirect;
    logic [31:0] exp_redirect_pc;
    logic        exp_illegal;
} vector_t;

localparam int num_vectors = 30;

// zicsr funct3 codes
localparam logic [2:0] f_rw  = 3'b001;
localparam logic [2:0] f_rs  = 3'b010;
localparam logic [2:0] f_rc  = 3'b011;
localparam logic [2:0] f_rwi = 3'b101;
localparam logic [2:0] f_rsi = 3'b110;
localparam logic [2:0] f_rci = 3'b111;

localparam logic [31:0] instr_ecall = 32'h0000_0073;
localparam logic [31:0] instr_mret  = 32'h3020_0073;
localparam logic [31:0] instr_wfi   = 32'h1050_0073;

vector_t vectors [$];

function automatic void load_vectors();
    // reset values, src x0 means no write
    csr_row(f_rs,  csr_addr_mstatus, 5'd0,  5'd1, 32'h0,         32'h0000_1800);
    csr_row(f_rs,  csr_addr_mtvec,   5'd0,  5'd2, 32'h0,         32'h0000_0100);
    csr_row(f_rs,  csr_addr_mepc,    5'd0,  5'd3, 32'h0,         32'h0000_0000);
    csr_row(f_rs,  csr_addr_mcause,  5'd0,  5'd4, 32'h0,         32'h0000_0000);
    // read-modify-write, back to back
    csr_row(f_rw,  csr_addr_mtvec,   5'd6,  5'd5, 32'h0000_0200, 32'h0000_0100);
    csr_row(f_rs,  csr_addr_mtvec,   5'd0,  5'd5, 32'h0,         32'h0000_0200);
    csr_row(f_rs,  csr_addr_mstatus, 5'd8,  5'd7, 32'h0000_0008, 32'h0000_1800);
    csr_row(f_rc,  csr_addr_mstatus, 5'd9,  5'd7, 32'h0000_0800, 32'h0000_1808);
    csr_row(f_rs,  csr_addr_mstatus, 5'd0,  5'd1, 32'h0,         32'h0000_1008);
    // immediate forms ignore rs1_data
    csr_row(f_rwi, csr_addr_mcause,  5'd21, 5'd2, 32'hdead_beef, 32'h0000_0000);
    csr_row(f_rsi, csr_addr_mcause,  5'd10, 5'd3, 32'h0,         32'h0000_0015);
    csr_row(f_rci, csr_addr_mcause,  5'd0,  5'd4, 32'hffff_ffff, 32'h0000_001f);
    csr_row(f_rci, csr_addr_mcause,  5'd3,  5'd0, 32'h0,         32'h0000_001f);
    csr_row(f_rs,  csr_addr_mcause,  5'd0,  5'd6, 32'h0,         32'h0000_001c);
    csr_row(f_rw,  csr_addr_mepc,    5'd3,  5'd0, 32'h0000_0040, 32'h0000_0000);
    csr_row(f_rs,  csr_addr_mepc,    5'd0,  5'd2, 32'h0,         32'h0000_0040);
    // ecall with mie set and mpie clear
    trap_row(instr_ecall, 32'h0000_0480, 32'h0000_0200);
    csr_row(f_rs,  csr_addr_mepc,    5'd0,  5'd1, 32'h0,         32'h0000_0480);
    csr_row(f_rs,  csr_addr_mcause,  5'd0,  5'd2, 32'h0,         32'h0000_000b);
    csr_row(f_rs,  csr_addr_mstatus, 5'd0,  5'd3, 32'h0,         32'h0000_1080);
    csr_row(f_rw,  csr_addr_mepc,    5'd9,  5'd4, 32'h0000_0484, 32'h0000_0480);
    trap_row(instr_mret, 32'h0000_0600, 32'h0000_0484);
    csr_row(f_rs,  csr_addr_mstatus, 5'd0,  5'd5, 32'h0,         32'h0000_1088);
    // unknown address and bad SYSTEM encodings
    illegal_row(encode(f_rw, 12'h301, 5'd2, 5'd1), 32'hffff_ffff);
    csr_row(f_rs,  csr_addr_mstatus, 5'd0,  5'd1, 32'h0,         32'h0000_1088);
    illegal_row(encode(3'b100, csr_addr_mtvec, 5'd1, 5'd1), 32'hffff_ffff);
    illegal_row(instr_wfi, 32'h0);
    csr_row(f_rs,  csr_addr_mtvec,   5'd0,  5'd2, 32'h0,         32'h0000_0200);
    // idle cycle, the write must not happen
    add_row({1'b0, encode(f_rw, csr_addr_mtvec, 5'd2, 5'd1), 32'h0, 32'hffff_ffff},
            1'b0, 4'd0, 32'h0, 1'b0, 32'h0, 1'b0);
    csr_row(f_rs,  csr_addr_mtvec,   5'd0,  5'd3, 32'h0,         32'h0000_0200);
endfunction

`endif

/* tb/csr_unit_tb.sv */
// Testbench for the machine-mode CSR unit.
// Applies the request table from csr_vectors.svh, one row per clock, and
// checks each registered response on the next falling edge.

`timescale 1ns/1ps

module csr_unit_tb;
    import csr_pkg::*;

    localparam int half_period = 20;

    logic      clk;
    logic      rst;
    csr_req_t  req;
    csr_resp_t resp;
    string     where;

    `include "csr_vectors.svh"

    csr_unit #(
        .MTVEC_RESET (32'h0000_0100)
    ) csr_unit_i (
        .clk  (clk),
        .rst  (rst),
        .req  (req),
        .resp (resp)
    );

    always #half_period clk = ~clk;

    // zicsr instruction word from its fields
    function automatic logic [31:0] encode(input logic [2:0] funct3, input logic [11:0] csr,
                                           input logic [4:0] src, input logic [4:0] rd);
        return {csr, src, funct3, rd, 7'b1110011};
    endfunction

    function automatic void add_row(input csr_req_t r, input logic rd_we,
                                    input logic [3:0] rd,
                                    input logic [31:0] rd_data, input logic redirect,
                                    input logic [31:0] target, input logic illegal);
        vector_t v;
        v.req             = r;
        // every valid request is accepted and answered
        v.exp_valid       = r.valid;
        v.exp_rd_we       = rd_we;
        v.exp_rd          = rd;
        v.exp_rd_data     = rd_data;
        v.exp_redirect    = redirect;
        v.exp_redirect_pc = target;
        v.exp_illegal     = illegal;
        vectors.push_back(v);
    endfunction

    // rd gets the old value, rd x0 means no register write
    function automatic void csr_row(input logic [2:0] funct3, input logic [11:0] csr,
                                    input logic [4:0] src, input logic [4:0] rd,
                                    input logic [31:0] rs1_data, input logic [31:0] old_value);
        add_row({1'b1, encode(funct3, csr, src, rd), 32'h0, rs1_data},
                rd != 5'd0, rd[3:0], old_value, 1'b0, 32'h0, 1'b0);
    endfunction

    function automatic void trap_row(input logic [31:0] instr, input logic [31:0] pc,
                                     input logic [31:0] target);
        add_row({1'b1, instr, pc, 32'h0}, 1'b0, 4'd0, 32'h0, 1'b1, target, 1'b0);
    endfunction

    function automatic void illegal_row(input logic [31:0] instr, input logic [31:0] rs1_data);
        add_row({1'b1, instr, 32'h0, rs1_data}, 1'b0, 4'd0, 32'h0, 1'b0, 32'h0, 1'b1);
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s at %s: got 0x%08h, expected 0x%08h",
                     name, where, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "response mismatch");
        end
    endtask

    // data fields only matter when their flag is expected high
    task automatic check_row(input vector_t v);
        check_value("resp.valid", 32'(resp.valid), 32'(v.exp_valid));
        check_value("resp.rd_we", 32'(resp.rd_we), 32'(v.exp_rd_we));
        if (v.exp_rd_we) begin
            check_value("resp.rd", 32'(resp.rd), 32'(v.exp_rd));
            check_value("resp.rd_data", resp.rd_data, v.exp_rd_data);
        end
        check_value("resp.redirect", 32'(resp.redirect), 32'(v.exp_redirect));
        if (v.exp_redirect) begin
            check_value("resp.redirect_pc", resp.redirect_pc, v.exp_redirect_pc);
        end
        check_value("resp.illegal", 32'(resp.illegal), 32'(v.exp_illegal));
    endtask

    initial begin
        clk   = 1'b0;
        rst   = 1'b1;
        req   = '0;
        where = "reset";
        load_vectors();
        if (vectors.size() != num_vectors) begin
            $display("vector table holds %0d rows instead of %0d",
                     vectors.size(), num_vectors);
            $display("SIMULATION FAILED");
            $fatal(1, "bad vector table");
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst   = 1'b0;
        where = "end of reset";
        check_row('0);
        for (int i = 0; i < num_vectors; i++) begin
            req = vectors[i].req;
            @(negedge clk);
            where = $sformatf("row %0d", i);
            check_row(vectors[i]);
        end
        req   = '0;
        @(negedge clk);
        where = "idle after table";
        check_row('0);
        $display("SIMULATION PASSED");
        $finish;
    end

    // reset, table and drain fit well inside this budget
    initial begin
        #((num_vectors + 10) * 2 * half_period);
        $display("timeout: the table did not finish within %0d clock cycles",
                 num_vectors + 10);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule
